//--- video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Frame geometry, counted in characters and scanlines
`define CHARS_TOTAL 16
`define CHARS_SHOWN 8
`define ROWS_TOTAL 6
`define ROWS_SHOWN 4
`define SCANLINES 8

// Horizontal sync window in characters, end exclusive
`define HSYNC_START 10
`define HSYNC_END 12

// Character row that carries vertical sync
`define VSYNC_ROW 5

// Screen RAM size in 8-byte characters (8 KiB)
`define RAM_CHARS 1024

// Screen lengths for the wrap correction, indexed by screenSize
`define WRAP_LEN0 1024
`define WRAP_LEN1 768
`define WRAP_LEN2 512
`define WRAP_LEN3 640

`endif

//--- video_pkg.sv
package video_pkg;

	// One processor access, held until acknowledged
	typedef struct packed {
		logic rnw;
		// Bit 13 selects the control registers
		logic [13:0] addr;
		logic [7:0] wdata;
	} busReq_t;

	// Control register set
	typedef struct packed {
		logic twoBpp;
		logic [1:0] screenSize;
		// Screen start, in characters
		logic [9:0] startAddr;
	} videoCtrl_t;

	// CRTC outputs for one character slot
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic display;
		// Framestore address after wrap correction
		logic [9:0] charAddr;
		logic [2:0] line;
	} crtcOut_t;

	// Two bitplanes of four pixels each
	typedef struct packed {
		logic [3:0] hi;
		logic [3:0] lo;
	} pixelPlanes_t;

	// Fetched screen byte
	// mono: pixel i is bit 7-i
	// quad: pixel i is {hi[3-i], lo[3-i]}
	typedef union packed {
		logic [7:0] mono;
		pixelPlanes_t quad;
	} pixelByte_u;

endpackage

//--- crtcAddressGen.sv
`timescale 1ns/1ps
`include "video_config.svh"

module crtcAddressGen (
	input logic PIXELCLK,
	input logic reset,
	input logic charStrobe,
	input video_pkg::videoCtrl_t ctrl,
	output video_pkg::crtcOut_t crtc
);

	localparam int charW = $clog2(`CHARS_TOTAL);
	localparam int lineW = $clog2(`SCANLINES);
	localparam int rowW = $clog2(`ROWS_TOTAL);

	logic [charW-1:0] charCount;
	logic [lineW-1:0] lineCount;
	logic [rowW-1:0] rowCount;
	logic [9:0] rowAddr;
	logic [9:0] curAddr;
	logic [10:0] wrapLen;
	logic lastChar;
	logic lastLine;
	logic lastRow;

	// Adds and folds anything past the top of RAM back into the screen area
	function automatic logic [9:0] wrapAdd(input logic [9:0] base, input logic [10:0] inc,
			input logic [10:0] len);
		logic [10:0] sum;
		sum = {1'b0, base} + inc;
		if (sum >= 11'(`RAM_CHARS)) begin
			sum = sum - len;
		end
		return sum[9:0];
	endfunction

	always_comb begin
		case (ctrl.screenSize)
			2'd0: wrapLen = 11'(`WRAP_LEN0);
			2'd1: wrapLen = 11'(`WRAP_LEN1);
			2'd2: wrapLen = 11'(`WRAP_LEN2);
			default: wrapLen = 11'(`WRAP_LEN3);
		endcase
	end

	assign lastChar = charCount == charW'(`CHARS_TOTAL - 1);
	assign lastLine = lineCount == lineW'(`SCANLINES - 1);
	assign lastRow = rowCount == rowW'(`ROWS_TOTAL - 1);

	// Character, scanline and row counters
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			charCount <= '0;
			lineCount <= '0;
			rowCount <= '0;
		end else if (charStrobe) begin
			charCount <= lastChar ? '0 : charCount + 1'b1;
			if (lastChar) begin
				lineCount <= lastLine ? '0 : lineCount + 1'b1;
				if (lastLine) begin
					rowCount <= lastRow ? '0 : rowCount + 1'b1;
				end
			end
		end
	end

	// Framestore address, each scanline of a row restarts at rowAddr
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			rowAddr <= '0;
			curAddr <= '0;
		end else if (charStrobe) begin
			if (lastChar && lastLine && lastRow) begin
				// New frame picks up the start register
				rowAddr <= ctrl.startAddr;
				curAddr <= ctrl.startAddr;
			end else if (lastChar && lastLine) begin
				rowAddr <= wrapAdd(rowAddr, 11'(`CHARS_SHOWN), wrapLen);
				curAddr <= wrapAdd(rowAddr, 11'(`CHARS_SHOWN), wrapLen);
			end else if (lastChar) begin
				curAddr <= rowAddr;
			end else if (charCount < charW'(`CHARS_SHOWN - 1)) begin
				curAddr <= wrapAdd(curAddr, 11'd1, wrapLen);
			end
		end
	end

	assign crtc.display = (charCount < charW'(`CHARS_SHOWN)) &&
		(rowCount < rowW'(`ROWS_SHOWN));
	assign crtc.hsync = (charCount >= charW'(`HSYNC_START)) &&
		(charCount < charW'(`HSYNC_END));
	assign crtc.vsync = rowCount == rowW'(`VSYNC_ROW);
	assign crtc.charAddr = curAddr;
	assign crtc.line = lineCount;

endmodule

//--- videoMemory.sv
`timescale 1ns/1ps
`include "video_config.svh"

module videoMemory (
	input logic PIXELCLK,
	input logic reset,
	input logic busValid,
	input video_pkg::busReq_t bus,
	output logic busAck,
	output logic [7:0] readData,
	input video_pkg::crtcOut_t crtc,
	output logic charStrobe,
	output logic fetchValid,
	output video_pkg::pixelByte_u fetchData,
	output video_pkg::videoCtrl_t ctrl
);

	localparam int ramBytes = `RAM_CHARS * 8;
	localparam int ramAddrW = $clog2(ramBytes);

	logic [7:0] ram [0:ramBytes-1];
	logic [2:0] phase;
	logic videoSlot;
	logic procSlot;
	logic regSel;
	logic [ramAddrW-1:0] videoAddr;
	logic [ramAddrW-1:0] procAddr;
	logic [7:0] regValue;

	// Video owns phase 0, the processor phase 4
	assign videoSlot = phase == 3'd0;
	assign procSlot = (phase == 3'd4) && busValid;
	assign charStrobe = phase == 3'd7;

	assign regSel = bus.addr[13];
	assign videoAddr = {crtc.charAddr, crtc.line};
	assign procAddr = bus.addr[ramAddrW-1:0];

	// Slot phase counter
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Acknowledge and fetch strobes trail their slot by one cycle
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			busAck <= 1'b0;
			fetchValid <= 1'b0;
		end else begin
			busAck <= procSlot;
			fetchValid <= videoSlot;
		end
	end

	// Control registers
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			ctrl <= '0;
		end else if (procSlot && regSel && !bus.rnw) begin
			case (bus.addr[1:0])
				2'd0: ctrl.twoBpp <= bus.wdata[0];
				2'd1: ctrl.screenSize <= bus.wdata[1:0];
				2'd2: ctrl.startAddr[9:8] <= bus.wdata[1:0];
				default: ctrl.startAddr[7:0] <= bus.wdata;
			endcase
		end
	end

	always_comb begin
		case (bus.addr[1:0])
			2'd0: regValue = {7'd0, ctrl.twoBpp};
			2'd1: regValue = {6'd0, ctrl.screenSize};
			2'd2: regValue = {6'd0, ctrl.startAddr[9:8]};
			default: regValue = ctrl.startAddr[7:0];
		endcase
	end

	// Shared screen RAM, one access per slot
	always_ff @(posedge PIXELCLK) begin
		if (videoSlot) begin
			fetchData.mono <= ram[videoAddr];
		end else if (procSlot) begin
			if (bus.rnw) begin
				readData <= regSel ? regValue : ram[procAddr];
			end else if (!regSel) begin
				ram[procAddr] <= bus.wdata;
			end
		end
	end

endmodule

//--- pixelSerializer.sv
`timescale 1ns/1ps

module pixelSerializer (
	input logic PIXELCLK,
	input logic reset,
	input logic fetchValid,
	input video_pkg::pixelByte_u fetchData,
	input video_pkg::crtcOut_t crtc,
	input video_pkg::videoCtrl_t ctrl,
	output logic hsync,
	output logic vsync,
	output logic blank,
	output logic [2:0] colour
);

	video_pkg::pixelByte_u shifter;
	logic twoBppQ;
	logic holdOdd;
	logic displayQ;
	logic hsyncQ;
	logic vsyncQ;
	logic [2:0] palette;

	// Flags and mode captured with the byte so they line up with its pixels
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			displayQ <= 1'b0;
			hsyncQ <= 1'b0;
			vsyncQ <= 1'b0;
			twoBppQ <= 1'b0;
			holdOdd <= 1'b0;
		end else if (fetchValid) begin
			displayQ <= crtc.display;
			hsyncQ <= crtc.hsync;
			vsyncQ <= crtc.vsync;
			twoBppQ <= ctrl.twoBpp;
			holdOdd <= 1'b0;
		end else begin
			holdOdd <= ~holdOdd;
		end
	end

	// Shift out MSB first, 2bpp shifts every other cycle
	always_ff @(posedge PIXELCLK) begin
		if (fetchValid) begin
			shifter <= fetchData;
		end else if (!twoBppQ) begin
			shifter.mono <= {shifter.mono[6:0], 1'b0};
		end else if (holdOdd) begin
			shifter.quad.hi <= {shifter.quad.hi[2:0], 1'b0};
			shifter.quad.lo <= {shifter.quad.lo[2:0], 1'b0};
		end
	end

	// Fixed palette, colour is {R, G, B}
	always_comb begin
		if (!twoBppQ) begin
			palette = shifter.mono[7] ? 3'b111 : 3'b000;
		end else begin
			case ({shifter.quad.hi[3], shifter.quad.lo[3]})
				2'd0: palette = 3'b000;
				2'd1: palette = 3'b100;
				// yellow
				2'd2: palette = 3'b110;
				default: palette = 3'b111;
			endcase
		end
	end

	assign colour = displayQ ? palette : 3'b000;
	assign blank = !displayQ;
	assign hsync = hsyncQ;
	assign vsync = vsyncQ;

endmodule

//--- videoSubsystem.sv
`timescale 1ns/1ps

module videoSubsystem (
	input logic PIXELCLK,
	input logic reset,
	input logic busValid,
	input video_pkg::busReq_t bus,
	output logic busAck,
	output logic [7:0] readData,
	output logic hsync,
	output logic vsync,
	output logic blank,
	output logic [2:0] colour
);

	logic charStrobe;
	logic fetchValid;
	video_pkg::crtcOut_t crtc;
	video_pkg::pixelByte_u fetchData;
	video_pkg::videoCtrl_t ctrl;

	// Timing and framestore address
	crtcAddressGen crtcAddressGen_inst (
		.PIXELCLK(PIXELCLK),
		.reset(reset),
		.charStrobe(charStrobe),
		.ctrl(ctrl),
		.crtc(crtc)
	);

	// Screen RAM shared between video and processor
	videoMemory videoMemory_inst (
		.PIXELCLK(PIXELCLK),
		.reset(reset),
		.busValid(busValid),
		.bus(bus),
		.busAck(busAck),
		.readData(readData),
		.crtc(crtc),
		.charStrobe(charStrobe),
		.fetchValid(fetchValid),
		.fetchData(fetchData),
		.ctrl(ctrl)
	);

	pixelSerializer pixelSerializer_inst (
		.PIXELCLK(PIXELCLK),
		.reset(reset),
		.fetchValid(fetchValid),
		.fetchData(fetchData),
		.crtc(crtc),
		.ctrl(ctrl),
		.hsync(hsync),
		.vsync(vsync),
		.blank(blank),
		.colour(colour)
	);

endmodule

//--- videoSubsystem_assertions.sv
`timescale 1ns/1ps

module slotAssertions (
	input logic PIXELCLK,
	input logic reset,
	input logic [2:0] phase,
	input logic busValid,
	input logic busAck,
	input logic fetchValid
);

	// Processor acknowledge only from a granted phase-4 slot
	ackHasCause: assert property (@(posedge PIXELCLK) disable iff (reset)
		busAck |-> $past(phase == 3'd4 && busValid))
		else $error("busAck without a phase-4 request");

	ackFollowsGrant: assert property (@(posedge PIXELCLK) disable iff (reset)
		(phase == 3'd4 && busValid) |=> busAck)
		else $error("phase-4 request was not acknowledged");

	ackIsPulse: assert property (@(posedge PIXELCLK) disable iff (reset)
		busAck |=> !busAck)
		else $error("busAck held longer than one cycle");

	// Video fetch strobe trails phase 0
	fetchHasCause: assert property (@(posedge PIXELCLK) disable iff (reset)
		fetchValid |-> $past(phase == 3'd0))
		else $error("fetchValid outside the cycle after phase 0");

	fetchFollowsSlot: assert property (@(posedge PIXELCLK) disable iff (reset)
		(phase == 3'd0) |=> fetchValid)
		else $error("phase 0 without a video fetch");

endmodule

bind videoMemory slotAssertions slotAssertions_inst (
	.PIXELCLK(PIXELCLK),
	.reset(reset),
	.phase(phase),
	.busValid(busValid),
	.busAck(busAck),
	.fetchValid(fetchValid)
);

//--- tb_videoSubsystem.sv
`timescale 1ns/1ps
`include "video_config.svh"

module tb_videoSubsystem;

	localparam int ramBytes = `RAM_CHARS * 8;
	localparam int frameCycles = `CHARS_TOTAL * 8 * `SCANLINES * `ROWS_TOTAL;

	logic PIXELCLK;
	logic reset;
	logic busValid;
	video_pkg::busReq_t bus;
	logic busAck;
	logic [7:0] readData;
	logic hsync;
	logic vsync;
	logic blank;
	logic [2:0] colour;

	// Reference model state
	logic [7:0] modelRam [0:ramBytes-1];
	logic modelTwoBpp;
	logic [1:0] modelSize;
	logic [9:0] modelStart;
	logic [2:0] expPixels [$];
	logic [2:0] gotPixels [$];
	int mismatchCount;
	int failCount;

	videoSubsystem videoSubsystem_inst (
		.PIXELCLK(PIXELCLK),
		.reset(reset),
		.busValid(busValid),
		.bus(bus),
		.busAck(busAck),
		.readData(readData),
		.hsync(hsync),
		.vsync(vsync),
		.blank(blank),
		.colour(colour)
	);

	initial begin
		PIXELCLK = 1'b0;
		forever #20 PIXELCLK = ~PIXELCLK;
	end

	task automatic reportMismatch(input string testName, input int expected, input int actual);
		$display("MISMATCH %s expected %0h actual %0h", testName, expected, actual);
		mismatchCount++;
	endtask

	task automatic reportFailure(input string what);
		$display("FAILURE %s", what);
		failCount++;
	endtask

	function automatic logic [7:0] regValue(input logic [1:0] idx);
		case (idx)
			2'd0: return {7'd0, modelTwoBpp};
			2'd1: return {6'd0, modelSize};
			2'd2: return {6'd0, modelStart[9:8]};
			default: return modelStart[7:0];
		endcase
	endfunction

	function automatic void setModelReg(input logic [1:0] idx, input logic [7:0] value);
		case (idx)
			2'd0: modelTwoBpp = value[0];
			2'd1: modelSize = value[1:0];
			2'd2: modelStart[9:8] = value[1:0];
			default: modelStart[7:0] = value;
		endcase
	endfunction

	// One processor access; writes update the model, reads are checked against it
	task automatic busAccess(input string testName, input logic rnw, input logic [13:0] addr,
			input logic [7:0] wdata);
		int waited;
		logic [7:0] expected;
		expected = addr[13] ? regValue(addr[1:0]) : modelRam[addr[12:0]];
		bus.rnw = rnw;
		bus.addr = addr;
		bus.wdata = wdata;
		busValid = 1'b1;
		waited = 0;
		do begin
			@(negedge PIXELCLK);
			waited++;
		end while (!busAck && waited < 12);
		busValid = 1'b0;
		if (!busAck) begin
			reportFailure($sformatf("%s: no busAck after %0d cycles", testName, waited));
		end else begin
			// Request cycle counts too, so 9 cycles at most
			if (waited > 8) begin
				reportFailure($sformatf("%s: busAck took %0d cycles", testName, waited + 1));
			end
			if (rnw && readData !== expected) begin
				reportMismatch(testName, int'(expected), int'(readData));
			end
			if (!rnw && addr[13]) setModelReg(addr[1:0], wdata);
			else if (!rnw) modelRam[addr[12:0]] = wdata;
			@(negedge PIXELCLK);
			if (busAck) reportFailure($sformatf("%s: busAck high for a second cycle", testName));
		end
	endtask

	task automatic setControl(input logic twoBpp, input logic [1:0] size, input logic [9:0] start);
		busAccess("setControl", 1'b0, 14'h2000, {7'd0, twoBpp});
		busAccess("setControl", 1'b0, 14'h2001, {6'd0, size});
		busAccess("setControl", 1'b0, 14'h2002, {6'd0, start[9:8]});
		busAccess("setControl", 1'b0, 14'h2003, start[7:0]);
	endtask

	task automatic waitVsync(input logic level);
		int waited;
		waited = 0;
		while (vsync !== level && waited < 2 * frameCycles) begin
			@(negedge PIXELCLK);
			waited++;
		end
		if (vsync !== level) reportFailure($sformatf("vsync never went to %0b", level));
	endtask

	// Step through the framestore, folding past the top of RAM by the screen length
	function automatic logic [9:0] nextAddr(input logic [9:0] addr, input int step,
			input logic [1:0] size);
		int sum;
		int len;
		case (size)
			2'd0: len = `WRAP_LEN0;
			2'd1: len = `WRAP_LEN1;
			2'd2: len = `WRAP_LEN2;
			default: len = `WRAP_LEN3;
		endcase
		sum = int'(addr) + step;
		if (sum >= `RAM_CHARS) sum = sum - len;
		return sum[9:0];
	endfunction

	// Black, red, yellow, white as {R, G, B}
	function automatic logic [2:0] quadColour(input logic [1:0] value);
		case (value)
			2'd0: return 3'b000;
			2'd1: return 3'b100;
			2'd2: return 3'b110;
			default: return 3'b111;
		endcase
	endfunction

	task automatic buildExpected();
		logic [9:0] rowBase;
		logic [9:0] addr;
		logic [7:0] pix;
		logic [1:0] pair;
		expPixels.delete();
		rowBase = modelStart;
		for (int r = 0; r < `ROWS_SHOWN; r++) begin
			for (int l = 0; l < `SCANLINES; l++) begin
				addr = rowBase;
				for (int c = 0; c < `CHARS_SHOWN; c++) begin
					pix = modelRam[{addr, 3'(l)}];
					for (int i = 7; i >= 0 && !modelTwoBpp; i--) begin
						expPixels.push_back(pix[i] ? 3'b111 : 3'b000);
					end
					// Planes are the high and low nibble, each pixel shown twice
					for (int i = 3; i >= 0 && modelTwoBpp; i--) begin
						pair = {pix[4 + i], pix[i]};
						expPixels.push_back(quadColour(pair));
						expPixels.push_back(quadColour(pair));
					end
					addr = nextAddr(addr, 1, modelSize);
				end
			end
			rowBase = nextAddr(rowBase, `CHARS_SHOWN, modelSize);
		end
	endtask

	// Capture from the end of one vsync to the end of the next
	task automatic checkFrame(input string testName);
		int waited;
		int hsyncCount;
		int vsyncCount;
		int vsyncCycles;
		logic prevH;
		logic prevV;
		buildExpected();
		waitVsync(1'b0);
		waitVsync(1'b1);
		waitVsync(1'b0);
		gotPixels.delete();
		waited = 0;
		hsyncCount = 0;
		vsyncCount = 0;
		vsyncCycles = 0;
		prevH = hsync;
		prevV = vsync;
		while (waited < 2 * frameCycles) begin
			if (!blank) gotPixels.push_back(colour);
			if (vsync) vsyncCycles++;
			@(negedge PIXELCLK);
			waited++;
			if (hsync && !prevH) hsyncCount++;
			if (vsync && !prevV) vsyncCount++;
			if (!vsync && prevV) break;
			prevH = hsync;
			prevV = vsync;
		end
		if (waited >= 2 * frameCycles) reportFailure({testName, ": frame never ended"});
		if (hsyncCount != `ROWS_TOTAL * `SCANLINES) begin
			reportMismatch({testName, " hsync pulses"}, `ROWS_TOTAL * `SCANLINES, hsyncCount);
		end
		if (vsyncCount != 1) reportMismatch({testName, " vsync pulses"}, 1, vsyncCount);
		if (vsyncCycles != `SCANLINES * `CHARS_TOTAL * 8) begin
			reportMismatch({testName, " vsync cycles"}, `SCANLINES * `CHARS_TOTAL * 8,
				vsyncCycles);
		end
		if (gotPixels.size() != expPixels.size()) begin
			reportMismatch({testName, " pixel count"}, expPixels.size(), gotPixels.size());
		end else begin
			for (int i = 0; i < expPixels.size(); i++) begin
				if (gotPixels[i] !== expPixels[i]) begin
					reportMismatch($sformatf("%s pixel %0d", testName, i),
						int'(expPixels[i]), int'(gotPixels[i]));
				end
			end
		end
	endtask

	initial begin
		int unsigned r;
		void'($urandom(32'h3c94b151));
		reset = 1'b1;
		busValid = 1'b0;
		bus = '0;
		mismatchCount = 0;
		failCount = 0;
		modelTwoBpp = 1'b0;
		modelSize = 2'd0;
		modelStart = 10'd0;
		repeat (5) @(posedge PIXELCLK);
		@(negedge PIXELCLK);
		reset = 1'b0;

		@(negedge PIXELCLK);
		if (blank !== 1'b1) reportMismatch("reset blank", 1, int'(blank));
		if (busAck !== 1'b0) reportMismatch("reset busAck", 0, int'(busAck));
		for (int i = 0; i < 4; i++) begin
			busAccess("reset registers", 1'b1, 14'h2000 + 14'(i), 8'd0);
		end

		// Random screen contents everywhere
		for (int a = 0; a < ramBytes; a++) begin
			r = $urandom();
			busAccess("fill", 1'b0, 14'(a), r[7:0]);
		end

		// Mixed register and RAM traffic
		for (int n = 0; n < 400; n++) begin
			r = $urandom();
			if (r[9:8] == 2'd0) begin
				busAccess("readback", 1'b0, {1'b1, 11'd0, r[1:0]}, r[17:10]);
			end else if (r[9:8] == 2'd1) begin
				busAccess("readback", 1'b0, {1'b0, r[30:18]}, r[17:10]);
			end else begin
				busAccess("readback", 1'b1,
					r[31] ? {1'b1, 11'd0, r[19:18]} : {1'b0, r[30:18]}, 8'd0);
			end
		end

		setControl(1'b0, 2'd0, 10'd0);
		checkFrame("frame 1bpp");
		setControl(1'b1, 2'd0, 10'd0);
		checkFrame("frame 2bpp");

		// Start near the top of RAM so every screen size wraps
		for (int s = 0; s < 4; s++) begin
			r = $urandom();
			setControl(r[4], 2'(s), {6'h3f, r[3:0]});
			checkFrame($sformatf("wrap size %0d", s));
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+.
video_pkg.sv
crtcAddressGen.sv
videoMemory.sv
pixelSerializer.sv
videoSubsystem.sv
videoSubsystem_assertions.sv
tb_videoSubsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the video subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_videoSubsystem \
	-Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
exit 0
